//--- Bender.yml
package:
  name: switch

sources:
  - logic/chiplet_types_pkg.sv
  - logic/flit_buffers.sv
  - logic/route_compute.sv
  - logic/switch_reg_bank.sv
  - logic/switch_allocator.sv
  - logic/crossbar.sv
  - logic/switch.sv
  - target: test
    files:
      - test/switch_checker.sv
      - test/switch_tb.sv

//--- switch.f
logic/chiplet_types_pkg.sv
logic/flit_buffers.sv
logic/route_compute.sv
logic/switch_reg_bank.sv
logic/switch_allocator.sv
logic/crossbar.sv
logic/switch.sv
test/switch_checker.sv
test/switch_tb.sv

//--- test/switch_tb.sv
`timescale 1ns/1ps

module switch_tb;

    localparam int MAX_CYCLES = 2000;
    localparam int NUM_DATA = 150;
    localparam int IDLE_GAP = 8;

    logic clk;
    logic rst_n;
    chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] in;
    logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_in;
    logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0] buffer_available;
    chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] out;
    logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_out;
    logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0] credit_granted;

    logic [31:0] lfsr;
    int cycle_count = 0;
    int sent_count;
    int recv_count;
    // Credits the sink still has to return
    int owed [3][2];
    logic hold;
    logic want [3];
    chiplet_types_pkg::flit_t want_flit [3];
    logic strobed_last [3];
    logic [7:0] seq_next [8];

    switch u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .in(in),
        .data_ready_in(data_ready_in),
        .buffer_available(buffer_available),
        .out(out),
        .data_ready_out(data_ready_out),
        .credit_granted(credit_granted)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (u_dut.u_checker.error_count != 0) begin
            report_failure($sformatf("Checker assertion failed at %0t", $time));
        end else if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles at %0t", cycle_count, $time));
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic chiplet_types_pkg::flit_t make_data(input int port, input int vc,
                                                           input int dest);
        chiplet_types_pkg::flit_t f;
        int tag;
        tag = port * 2 + vc;
        f.vc = 1'(vc);
        f.payload = {4'h1, 5'(dest), 7'd0, 8'(tag), seq_next[tag]};
        seq_next[tag] = seq_next[tag] + 8'd1;
        return f;
    endfunction

    function automatic chiplet_types_pkg::flit_t make_cfg(input int dest, input int idx,
                                                          input int port, input int vc);
        chiplet_types_pkg::flit_t f;
        f.vc = 1'(vc);
        f.payload = {4'h8, 5'(dest), 5'(idx), 2'(port), 16'h0};
        return f;
    endfunction

    // One clock: watch outputs, return credits, drive pending writes
    task automatic step();
        logic [2:0][1:0] give;
        logic [2:0] strobe;
        int b;
        @(posedge clk);
        for (int o = 0; o < 3; o++) begin
            if (data_ready_out[o]) begin
                owed[o][out[o].vc]++;
                if (out[o].payload[31:28] == 4'h1) begin
                    recv_count++;
                end
            end
        end
        give = '0;
        for (int o = 0; o < 3; o++) begin
            for (int v = 0; v < 2; v++) begin
                if (!hold && owed[o][v] > 0) begin
                    take_bits(1, b);
                    if (b != 0) begin
                        give[o][v] = 1'b1;
                        owed[o][v]--;
                    end
                end
            end
        end
        credit_granted <= give;
        strobe = '0;
        // A port writes at most every other cycle, so availability is current
        for (int p = 0; p < 3; p++) begin
            if (want[p] && !strobed_last[p] && buffer_available[p][want_flit[p].vc]) begin
                in[p] <= want_flit[p];
                strobe[p] = 1'b1;
                want[p] = 1'b0;
                if (want_flit[p].payload[31:28] == 4'h1) begin
                    sent_count++;
                end
            end
        end
        data_ready_in <= strobe;
        for (int p = 0; p < 3; p++) begin
            strobed_last[p] = strobe[p];
        end
    endtask

    task automatic queue_flit(input int port, input chiplet_types_pkg::flit_t f);
        while (want[port]) begin
            step();
        end
        want[port] = 1'b1;
        want_flit[port] = f;
    endtask

    task automatic flush();
        while (want[0] || want[1] || want[2]) begin
            step();
        end
    endtask

    function automatic int owed_total();
        int sum;
        sum = 0;
        for (int o = 0; o < 3; o++) begin
            sum += owed[o][0] + owed[o][1];
        end
        return sum;
    endfunction

    task automatic wait_idle(input int n);
        int idle;
        idle = 0;
        while (idle < n) begin
            step();
            if (data_ready_out != '0 || owed_total() != 0) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    // Same FIFO for both writes of an entry keeps their order
    task automatic send_config(input int idx, input int port);
        queue_flit(idx % 3, make_cfg(5, idx, port, idx % 2));
        flush();
    endtask

    initial begin
        int base;
        int p;
        int v;
        int d;
        int g;
        clk = 1'b0;
        rst_n = 1'b0;
        in = '0;
        data_ready_in = '0;
        credit_granted = '0;
        lfsr = 32'h5401_1ad0;
        sent_count = 0;
        recv_count = 0;
        hold = 1'b0;
        for (int i = 0; i < 3; i++) begin
            want[i] = 1'b0;
            strobed_last[i] = 1'b0;
            want_flit[i] = '0;
            owed[i][0] = 0;
            owed[i][1] = 0;
        end
        for (int t = 0; t < 8; t++) begin
            seq_next[t] = 8'd0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Program nodes 0 to 7, each entry rewritten once
        for (int n = 0; n < 8; n++) begin
            send_config(n, (n + 1) % 3);
            send_config(n, n % 3);
        end
        send_config(9, 2);
        wait_idle(IDLE_GAP);

        // Config for another node passes through
        queue_flit(1, make_cfg(9, 3, 1, 0));
        flush();
        wait_idle(IDLE_GAP);

        // Drain output 1 vc 0 of credits, then fill input 0 vc 0
        hold = 1'b1;
        base = recv_count;
        repeat (chiplet_types_pkg::BUFFER_DEPTH) queue_flit(0, make_data(0, 0, 1));
        flush();
        while (recv_count < base + chiplet_types_pkg::BUFFER_DEPTH) begin
            step();
        end
        repeat (chiplet_types_pkg::BUFFER_DEPTH) queue_flit(0, make_data(0, 0, 1));
        flush();
        repeat (3) step();
        if (buffer_available[0][0] !== 1'b0) begin
            report_failure($sformatf("Mismatch at %0t: blocked FIFO still available", $time));
        end
        hold = 1'b0;

        // Random traffic
        for (int i = 0; i < NUM_DATA; i++) begin
            take_bits(2, p);
            p = p % 3;
            take_bits(1, v);
            take_bits(3, d);
            queue_flit(p, make_data(p, v, d));
            take_bits(2, g);
            repeat (g) step();
        end
        flush();
        wait_idle(16);

        if (sent_count != recv_count || u_dut.u_checker.error_count != 0) begin
            report_failure($sformatf("Mismatch at %0t: sent %0d data flits, received %0d",
                $time, sent_count, recv_count));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- test/switch_checker.sv
`timescale 1ns/1ps

module switch_checker (
    input logic clk,
    input logic rst_n,
    input chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] in,
    input logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_in,
    input logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
          buffer_available,
    input chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] out,
    input logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_out,
    input logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
          credit_granted
);

    // Shadow of the routing table, taken from config flits at the inputs
    logic [1:0] shadow [chiplet_types_pkg::TABLE_SIZE];
    int credit_cnt [chiplet_types_pkg::NUM_PORTS][chiplet_types_pkg::NUM_VCS];
    // Last sequence number per source tag
    logic [7:0] last_seq [8];
    logic seen [8];
    int error_count = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < chiplet_types_pkg::TABLE_SIZE; i++) begin
                shadow[i] <= 2'd0;
            end
            for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
                for (int v = 0; v < chiplet_types_pkg::NUM_VCS; v++) begin
                    credit_cnt[o][v] <= chiplet_types_pkg::BUFFER_DEPTH;
                end
            end
            for (int t = 0; t < 8; t++) begin
                seen[t] <= 1'b0;
                last_seq[t] <= 8'd0;
            end
        end else begin
            for (int p = 0; p < chiplet_types_pkg::NUM_PORTS; p++) begin
                if (data_ready_in[p] && buffer_available[p][in[p].vc]
                        && in[p].payload[31:28] == 4'h8 && in[p].payload[27:23] == 5'd5) begin
                    shadow[in[p].payload[22:18]] <= in[p].payload[17:16];
                end
            end
            for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
                for (int v = 0; v < chiplet_types_pkg::NUM_VCS; v++) begin
                    credit_cnt[o][v] <= credit_cnt[o][v]
                        - int'(data_ready_out[o] && out[o].vc == v)
                        + int'(credit_granted[o][v]);
                end
                if (data_ready_out[o] && out[o].payload[31:28] == 4'h1) begin
                    seen[out[o].payload[10:8]] <= 1'b1;
                    last_seq[out[o].payload[10:8]] <= out[o].payload[7:0];
                end
            end
        end
    end

    // Right after reset
    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (data_ready_out == '0) && (&buffer_available))
    else begin
        $error("Mismatch at %0t: outputs not idle after reset", $time);
        error_count++;
    end

    for (genvar p = 0; p < chiplet_types_pkg::NUM_PORTS; p++) begin : g_in
        a_no_full_write: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_in[p] |-> buffer_available[p][in[p].vc])
        else begin
            $error("Write into a full FIFO on input %0d at %0t", p, $time);
            error_count++;
        end
    end

    for (genvar o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin : g_out
        a_no_local_cfg: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[o] |->
                !(out[o].payload[31:28] == 4'h8 && out[o].payload[27:23] == 5'd5))
        else begin
            $error("Config flit for this node left on port %0d at %0t", o, $time);
            error_count++;
        end

        // Data and foreign config flits follow the table
        a_route: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[o] |-> shadow[out[o].payload[27:23]] == o)
        else begin
            $error("Mismatch at %0t: dest %0d left on port %0d", $time,
                out[o].payload[27:23], o);
            error_count++;
        end

        a_credit: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[o] |-> credit_cnt[o][out[o].vc] != 0)
        else begin
            $error("Flit sent without credit on port %0d at %0t", o, $time);
            error_count++;
        end

        a_vc: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[o] && out[o].payload[31:28] == 4'h1 |->
                out[o].vc == out[o].payload[8])
        else begin
            $error("Mismatch at %0t: vc changed on port %0d", $time, o);
            error_count++;
        end

        a_order: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[o] && out[o].payload[31:28] == 4'h1 |->
                !seen[out[o].payload[10:8]]
                || out[o].payload[7:0] > last_seq[out[o].payload[10:8]])
        else begin
            $error("Mismatch at %0t: sequence out of order on port %0d", $time, o);
            error_count++;
        end
    end

endmodule

bind switch switch_checker u_checker (.*);

//--- logic/switch.sv
`timescale 1ns/1ps

module switch (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] in,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_in,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
                 buffer_available,
    output chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] out,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_out,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
                 credit_granted
);

    chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_BUFFERS-1:0] head;
    logic [chiplet_types_pkg::NUM_BUFFERS-1:0] empty;
    logic [chiplet_types_pkg::NUM_BUFFERS-1:0] routed;
    chiplet_types_pkg::port_id_t [chiplet_types_pkg::NUM_BUFFERS-1:0] route;
    logic [chiplet_types_pkg::NUM_BUFFERS-1:0] claim_pop;
    logic [chiplet_types_pkg::NUM_BUFFERS-1:0] grant_pop;
    chiplet_types_pkg::route_req_t cfg_write;
    chiplet_types_pkg::node_id_t lookup_index;
    chiplet_types_pkg::port_id_t table_port;
    logic [chiplet_types_pkg::NUM_PORTS-1:0] grant_valid;
    chiplet_types_pkg::buf_id_t [chiplet_types_pkg::NUM_PORTS-1:0] grant_buf;

    // Claims and grants never name the same buffer
    flit_buffers u_buffers (
        .clk(clk),
        .rst_n(rst_n),
        .in(in),
        .data_ready_in(data_ready_in),
        .pop(claim_pop | grant_pop),
        .head(head),
        .empty(empty),
        .buffer_available(buffer_available)
    );

    route_compute u_route_compute (
        .clk(clk),
        .rst_n(rst_n),
        .head(head),
        .empty(empty),
        .table_port(table_port),
        .grant_pop(grant_pop),
        .lookup_index(lookup_index),
        .routed(routed),
        .route(route),
        .claim_pop(claim_pop),
        .cfg_write(cfg_write)
    );

    switch_reg_bank u_reg_bank (
        .clk(clk),
        .rst_n(rst_n),
        .cfg_write(cfg_write),
        .lookup_index(lookup_index),
        .table_port(table_port)
    );

    switch_allocator u_allocator (
        .clk(clk),
        .rst_n(rst_n),
        .head(head),
        .routed(routed),
        .route(route),
        .credit_granted(credit_granted),
        .grant_valid(grant_valid),
        .grant_buf(grant_buf),
        .grant_pop(grant_pop)
    );

    crossbar u_crossbar (
        .clk(clk),
        .rst_n(rst_n),
        .head(head),
        .grant_valid(grant_valid),
        .grant_buf(grant_buf),
        .out(out),
        .data_ready_out(data_ready_out)
    );

endmodule

//--- logic/crossbar.sv
`timescale 1ns/1ps

module crossbar (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_BUFFERS-1:0] head,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0] grant_valid,
    input  chiplet_types_pkg::buf_id_t [chiplet_types_pkg::NUM_PORTS-1:0] grant_buf,
    output chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] out,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_out
);

    // Valid is a one-cycle pulse per granted flit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ready_out <= '0;
        end else begin
            data_ready_out <= grant_valid;
        end
    end

    // Output register only loads on a grant
    always_ff @(posedge clk) begin
        for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
            if (grant_valid[o]) begin
                out[o] <= head[grant_buf[o]];
            end
        end
    end

endmodule

//--- logic/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_BUFFERS-1:0] head,
    input  logic [chiplet_types_pkg::NUM_BUFFERS-1:0] routed,
    input  chiplet_types_pkg::port_id_t [chiplet_types_pkg::NUM_BUFFERS-1:0] route,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
                 credit_granted,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0] grant_valid,
    output chiplet_types_pkg::buf_id_t [chiplet_types_pkg::NUM_PORTS-1:0] grant_buf,
    output logic [chiplet_types_pkg::NUM_BUFFERS-1:0] grant_pop
);

    chiplet_types_pkg::credit_t [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
        credits;
    logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0] credit_take;
    logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_BUFFERS-1:0] eligible;
    chiplet_types_pkg::buf_id_t [chiplet_types_pkg::NUM_PORTS-1:0] rr_ptr;

    // Routed to this output, and the flit's VC still has credit there
    always_comb begin
        for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
            for (int b = 0; b < chiplet_types_pkg::NUM_BUFFERS; b++) begin
                eligible[o][b] = routed[b]
                    && (route[b] == chiplet_types_pkg::port_id_t'(o))
                    && (credits[o][head[b].vc] != '0);
            end
        end
    end

    // One round-robin arbiter per output
    always_comb begin
        int idx;
        grant_valid = '0;
        grant_buf = rr_ptr;
        grant_pop = '0;
        for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
            for (int i = 1; i <= chiplet_types_pkg::NUM_BUFFERS; i++) begin
                idx = (int'(rr_ptr[o]) + i) % chiplet_types_pkg::NUM_BUFFERS;
                if (!grant_valid[o] && eligible[o][idx]) begin
                    grant_valid[o] = 1'b1;
                    grant_buf[o] = chiplet_types_pkg::buf_id_t'(idx);
                end
            end
            if (grant_valid[o]) begin
                grant_pop[grant_buf[o]] = 1'b1;
            end
        end
    end

    always_comb begin
        credit_take = '0;
        for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
            credit_take[o][head[grant_buf[o]].vc] = grant_valid[o];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
                rr_ptr[o] <= chiplet_types_pkg::buf_id_t'(chiplet_types_pkg::NUM_BUFFERS - 1);
                for (int v = 0; v < chiplet_types_pkg::NUM_VCS; v++) begin
                    credits[o][v] <= chiplet_types_pkg::credit_t'(chiplet_types_pkg::BUFFER_DEPTH);
                end
            end
        end else begin
            for (int o = 0; o < chiplet_types_pkg::NUM_PORTS; o++) begin
                if (grant_valid[o]) begin
                    rr_ptr[o] <= grant_buf[o];
                end
                // Take and return in the same cycle cancel out
                for (int v = 0; v < chiplet_types_pkg::NUM_VCS; v++) begin
                    if (credit_take[o][v] && !credit_granted[o][v]) begin
                        credits[o][v] <= credits[o][v] - 1'b1;
                    end else if (!credit_take[o][v] && credit_granted[o][v]) begin
                        credits[o][v] <= credits[o][v] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- logic/switch_reg_bank.sv
`timescale 1ns/1ps

module switch_reg_bank (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::route_req_t cfg_write,
    input  chiplet_types_pkg::node_id_t lookup_index,
    output chiplet_types_pkg::port_id_t table_port
);

    // Output port per destination node
    chiplet_types_pkg::port_id_t route_table [chiplet_types_pkg::TABLE_SIZE];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < chiplet_types_pkg::TABLE_SIZE; i++) begin
                route_table[i] <= '0;
            end
        end else if (cfg_write.valid) begin
            route_table[cfg_write.index] <= cfg_write.port;
        end
    end

    // Combinational lookup for route compute
    assign table_port = route_table[lookup_index];

endmodule

//--- logic/route_compute.sv
`timescale 1ns/1ps

module route_compute (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_BUFFERS-1:0] head,
    input  logic [chiplet_types_pkg::NUM_BUFFERS-1:0] empty,
    input  chiplet_types_pkg::port_id_t table_port,
    input  logic [chiplet_types_pkg::NUM_BUFFERS-1:0] grant_pop,
    output chiplet_types_pkg::node_id_t lookup_index,
    output logic [chiplet_types_pkg::NUM_BUFFERS-1:0] routed,
    output chiplet_types_pkg::port_id_t [chiplet_types_pkg::NUM_BUFFERS-1:0] route,
    output logic [chiplet_types_pkg::NUM_BUFFERS-1:0] claim_pop,
    output chiplet_types_pkg::route_req_t cfg_write
);

    chiplet_types_pkg::buf_id_t rr_ptr;
    chiplet_types_pkg::buf_id_t pick;
    logic pick_valid;
    chiplet_types_pkg::flit_t pick_flit;
    logic claim;
    logic [chiplet_types_pkg::NUM_BUFFERS-1:0] set_routed;

    // Round-robin search starting just after the last pick
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick = rr_ptr;
        for (int i = 1; i <= chiplet_types_pkg::NUM_BUFFERS; i++) begin
            idx = (int'(rr_ptr) + i) % chiplet_types_pkg::NUM_BUFFERS;
            if (!pick_valid && !empty[idx] && !routed[idx]) begin
                pick_valid = 1'b1;
                pick = chiplet_types_pkg::buf_id_t'(idx);
            end
        end
    end

    assign pick_flit = head[pick];
    assign lookup_index = chiplet_types_pkg::flit_dest(pick_flit);

    // Config flits for this node stop here and go to the table
    assign claim = pick_valid
        && (chiplet_types_pkg::flit_fmt(pick_flit) == chiplet_types_pkg::FMT_SWITCH_CFG)
        && (chiplet_types_pkg::flit_dest(pick_flit) == chiplet_types_pkg::NODE);

    always_comb begin
        claim_pop = '0;
        set_routed = '0;
        claim_pop[pick] = claim;
        set_routed[pick] = pick_valid && !claim;
        cfg_write.valid = claim;
        cfg_write.index = chiplet_types_pkg::node_id_t'(pick_flit.payload[22:18]);
        cfg_write.port = chiplet_types_pkg::port_id_t'(pick_flit.payload[17:16]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= chiplet_types_pkg::buf_id_t'(chiplet_types_pkg::NUM_BUFFERS - 1);
            routed <= '0;
        end else begin
            if (pick_valid) begin
                rr_ptr <= pick;
            end
            // A granted buffer drops its route, the new head gets routed again
            routed <= (routed & ~grant_pop) | set_routed;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_valid && !claim) begin
            route[pick] <= table_port;
        end
    end

endmodule

//--- logic/flit_buffers.sv
`timescale 1ns/1ps

module flit_buffers (
    input  logic clk,
    input  logic rst_n,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_PORTS-1:0] in,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0] data_ready_in,
    input  logic [chiplet_types_pkg::NUM_BUFFERS-1:0] pop,
    output chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_BUFFERS-1:0] head,
    output logic [chiplet_types_pkg::NUM_BUFFERS-1:0] empty,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0][chiplet_types_pkg::NUM_VCS-1:0]
                 buffer_available
);

    for (genvar b = 0; b < chiplet_types_pkg::NUM_BUFFERS; b++) begin : g_fifo
        // Input port and VC served by this FIFO
        localparam int P = b % chiplet_types_pkg::NUM_PORTS;
        localparam int V = b / chiplet_types_pkg::NUM_PORTS;

        chiplet_types_pkg::flit_t mem [chiplet_types_pkg::BUFFER_DEPTH];
        logic [chiplet_types_pkg::PTR_W-1:0] rd_ptr;
        logic [chiplet_types_pkg::PTR_W-1:0] wr_ptr;
        logic [chiplet_types_pkg::PTR_W:0] count;
        logic full;
        logic wen;
        logic ren;

        assign full = (count == (chiplet_types_pkg::PTR_W + 1)'(chiplet_types_pkg::BUFFER_DEPTH));

        // Steer by the flit's VC field, drop when full
        assign wen = data_ready_in[P] && (in[P].vc == chiplet_types_pkg::vc_id_t'(V)) && !full;
        assign ren = pop[b] && (count != '0);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count <= '0;
            end else begin
                if (wen) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (ren) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({wen, ren})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (wen) begin
                mem[wr_ptr] <= in[P];
            end
        end

        assign head[b] = mem[rd_ptr];
        assign empty[b] = (count == '0);
        assign buffer_available[P][V] = !full;
    end

endmodule

//--- logic/chiplet_types_pkg.sv
package chiplet_types_pkg;

    // Switch geometry
    localparam int NUM_PORTS = 3;
    localparam int NUM_VCS = 2;
    // Buffers are VC-major, index = vc * NUM_PORTS + port
    localparam int NUM_BUFFERS = NUM_PORTS * NUM_VCS;
    localparam int BUFFER_DEPTH = 4;
    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int TABLE_SIZE = 32;

    typedef logic [4:0] node_id_t;
    typedef logic [1:0] port_id_t;
    typedef logic [0:0] vc_id_t;
    typedef logic [2:0] buf_id_t;
    typedef logic [2:0] credit_t;
    typedef logic [3:0] fmt_t;

    // This switch's own node id
    localparam node_id_t NODE = 5'd5;

    // Packet formats, top nibble of the payload
    localparam fmt_t FMT_DATA = 4'h1;
    localparam fmt_t FMT_SWITCH_CFG = 4'h8;

    typedef struct packed {
        vc_id_t vc;
        logic [31:0] payload;
    } flit_t;

    // One routing table write
    typedef struct packed {
        logic valid;
        node_id_t index;
        port_id_t port;
    } route_req_t;

    function automatic fmt_t flit_fmt(flit_t f);
        return fmt_t'(f.payload[31:28]);
    endfunction

    function automatic node_id_t flit_dest(flit_t f);
        return node_id_t'(f.payload[27:23]);
    endfunction

endpackage
